// ==== Bender.yml ====
package:
  name: trace_logger

sources:
  - source/trace_pkg.sv
  - source/trace_ram.sv
  - source/trace_capture.sv
  - source/trace_readout.sv
  - source/trace_regs.sv
  - source/trace_logger.sv
  - target: test
    files:
      - tests/trace_clk_gen.sv
      - tests/trace_logger_chk.sv
      - tests/trace_logger_tb.sv

// ==== source/trace_capture.sv ====
/*
 * Trace capture
 * Detects changes on the probe, times the gap since the last entry
 * and writes {count, data} into the trace memory until it is full
 */
`default_nettype none

module trace_capture #(
  parameter int AW = 4,
  parameter int DW = 40,
  parameter int TW = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [DW-1:0]    probe,
  input  logic             start,
  output logic             running,
  output logic [AW-1:0]    pc,
  output logic             wr_en,
  output logic [AW-1:0]    wr_addr,
  output logic [TW+DW-1:0] wr_entry
);

  logic [DW-1:0] probe_d1;
  logic [DW-1:0] probe_d2;
  logic          diff;
  logic          ovf;    // Interval counter wrapped
  logic [TW-1:0] count;

  assign wr_en = running & (diff | ovf);
  assign wr_addr = pc;
  assign wr_entry = {count, probe_d2}; // Count above the data

  // Data pipeline, lines up with diff
  always_ff @(posedge clk) begin
    probe_d1 <= probe;
    probe_d2 <= probe_d1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      diff <= 1'b0;
      ovf <= 1'b0;
      count <= '0;
      pc <= '0;
      running <= 1'b0;
    end else begin
      diff <= probe_d1 != probe_d2;
      if (start) begin
        pc <= '0;
        running <= 1'b1;
        count <= TW'(1);
        ovf <= 1'b0;
      end else if (wr_en) begin
        count <= TW'(1);
        ovf <= 1'b0;
        pc <= pc + 1'b1;
        if (&pc) running <= 1'b0; // Last address written
      end else begin
        {ovf, count} <= {1'b0, count} + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/trace_logger.sv ====
/*
 * Trace logger top level
 * Change-triggered trace buffer with a Wishbone classic readout
 */
`default_nettype none

module trace_logger #(
  parameter int AW = 4,
  parameter int DW = 40,
  parameter int TW = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [trace_pkg::WB_AW-1:0]   wb_adr,
  input  logic [trace_pkg::WB_DW-1:0]   wb_dat_w,
  input  logic [trace_pkg::WB_DW/8-1:0] wb_sel,
  output logic [trace_pkg::WB_DW-1:0]   wb_dat_r,
  output logic                          wb_ack,
  input  logic [DW-1:0]                 probe,
  output logic                          running,
  output logic [AW-1:0]                 pc_mon
);

  logic                             start;
  logic [AW-1:0]                    rd_addr;
  logic [trace_pkg::WORD_IDX_W-1:0] word_idx;
  logic                             wr_en;
  logic [AW-1:0]                    wr_addr;
  logic [TW+DW-1:0]                 wr_entry;
  logic [TW+DW-1:0]                 rd_entry;
  logic [trace_pkg::WB_DW-1:0]      rd_word;

  trace_regs #(
    .AW(AW),
    .DW(DW),
    .TW(TW)
  ) u_trace_regs (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .running  (running),
    .pc       (pc_mon),
    .rd_word  (rd_word),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .start    (start),
    .rd_addr  (rd_addr),
    .word_idx (word_idx)
  );

  trace_capture #(
    .AW(AW),
    .DW(DW),
    .TW(TW)
  ) u_trace_capture (
    .clk      (clk),
    .rst      (rst),
    .probe    (probe),
    .start    (start),
    .running  (running),
    .pc       (pc_mon),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_entry (wr_entry)
  );

  trace_ram #(
    .AW(AW),
    .EW(TW + DW)
  ) u_trace_ram (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_entry (wr_entry),
    .rd_addr  (rd_addr),
    .rd_entry (rd_entry)
  );

  trace_readout #(
    .DW(DW),
    .TW(TW)
  ) u_trace_readout (
    .rd_entry (rd_entry),
    .word_idx (word_idx),
    .rd_word  (rd_word)
  );

endmodule

`default_nettype wire

// ==== source/trace_pkg.sv ====
/*
 * Trace logger shared definitions
 * Bus widths, register map and helpers for entry-to-word packing
 */
`default_nettype none

package trace_pkg;

  localparam int WB_DW = 32;        // One bus word
  localparam int WB_AW = 16;        // Word address
  localparam int REG_CTRL = 0;      // Bit 0 written as 1 starts capture
  localparam int REG_STATUS = 1;
  localparam int STATUS_PC_LSB = 16;
  localparam int MEM_BASE_BIT = 15; // Memory window select
  localparam int MAX_ENTRY_W = 256; // Limit on DW+TW
  localparam int WORD_IDX_W = $clog2(MAX_ENTRY_W / WB_DW);

  // Bus words per entry, rounded up to a power of two
  function automatic int words_per_entry(input int ew);
    int n;
    int w;
    n = (ew + WB_DW - 1) / WB_DW;
    w = 1;
    while (w < n) w = w * 2;
    return w;
  endfunction

  function automatic int word_sel_bits(input int ew);
    return $clog2(words_per_entry(ew));
  endfunction

endpackage

`default_nettype wire

// ==== source/trace_ram.sv ====
/*
 * Trace memory
 * Simple dual-port RAM, one write port and one registered read port
 */
`default_nettype none

module trace_ram #(
  parameter int AW = 4,
  parameter int EW = 48
) (
  input  logic          clk,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  logic [EW-1:0] wr_entry,
  input  logic [AW-1:0] rd_addr,
  output logic [EW-1:0] rd_entry
);

  logic [EW-1:0] mem [2**AW];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_entry;
    end
    rd_entry <= mem[rd_addr]; // One cycle read latency
  end

endmodule

`default_nettype wire

// ==== source/trace_readout.sv ====
/*
 * Trace readout
 * Picks one bus word out of a wide trace entry
 */
`default_nettype none

module trace_readout #(
  parameter int DW = 40,
  parameter int TW = 8
) (
  input  logic [TW+DW-1:0]                rd_entry,
  input  logic [trace_pkg::WORD_IDX_W-1:0] word_idx,
  output logic [trace_pkg::WB_DW-1:0]     rd_word
);

  import trace_pkg::*;

  logic [MAX_ENTRY_W-1:0] padded;

  // Zero fill above the entry so partial and unused words read clean
  assign padded = MAX_ENTRY_W'(rd_entry);

  assign rd_word = padded[word_idx*WB_DW +: WB_DW];

endmodule

`default_nettype wire

// ==== source/trace_regs.sv ====
/*
 * Trace register block
 * Wishbone classic slave with control, status and the memory window.
 * Registers ack one cycle after the strobe, memory reads after two
 */
`default_nettype none

module trace_regs #(
  parameter int AW = 4,
  parameter int DW = 40,
  parameter int TW = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [trace_pkg::WB_AW-1:0]      wb_adr,
  input  logic [trace_pkg::WB_DW-1:0]      wb_dat_w,
  input  logic [trace_pkg::WB_DW/8-1:0]    wb_sel,
  input  logic                             running,
  input  logic [AW-1:0]                    pc,
  input  logic [trace_pkg::WB_DW-1:0]      rd_word,
  output logic [trace_pkg::WB_DW-1:0]      wb_dat_r,
  output logic                             wb_ack,
  output logic                             start,
  output logic [AW-1:0]                    rd_addr,
  output logic [trace_pkg::WORD_IDX_W-1:0] word_idx
);

  import trace_pkg::*;

  localparam int WPE = words_per_entry(DW + TW);
  localparam int WSB = word_sel_bits(DW + TW);

  logic                    req;      // New bus access
  logic                    mem_sel;
  logic                    ctrl_sel;
  logic                    stat_sel;
  logic                    mem_pend; // RAM read in flight
  logic [MEM_BASE_BIT-1:0] win_adr;
  logic [WB_DW-1:0]        status_word;
  logic [WB_DW-1:0]        reg_word;

  assign req = wb_cyc & wb_stb & ~wb_ack & ~mem_pend;
  assign mem_sel = wb_adr[MEM_BASE_BIT];
  assign win_adr = wb_adr[MEM_BASE_BIT-1:0];
  assign ctrl_sel = ~mem_sel && (win_adr == MEM_BASE_BIT'(REG_CTRL));
  assign stat_sel = ~mem_sel && (win_adr == MEM_BASE_BIT'(REG_STATUS));

  // Entry address, the low bits pick the word within it
  assign rd_addr = AW'(win_adr >> WSB);

  always_comb begin
    status_word = '0;
    status_word[0] = running;
    status_word[STATUS_PC_LSB +: AW] = pc;
  end

  assign reg_word = stat_sel ? status_word : '0; // Control reads zero

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      mem_pend <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= req & wb_we & ctrl_sel & wb_sel[0] & wb_dat_w[0];
      mem_pend <= req & mem_sel;
      wb_ack <= (req & ~mem_sel) | (mem_pend & wb_cyc & wb_stb);
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      word_idx <= WORD_IDX_W'(win_adr) & WORD_IDX_W'(WPE - 1); // Same cycle as RAM addr
    end
    if (req & ~mem_sel) begin
      wb_dat_r <= reg_word;
    end else if (mem_pend) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== tests/trace_clk_gen.sv ====
/*
 * Testbench clock and reset
 * Period of 4, reset held for the first 10 cycles
 */
`default_nettype none

module trace_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/trace_logger_chk.sv ====
/*
 * Trace logger protocol checks
 * Bound into the top level, watches the bus ack and the capture pointer
 */
`default_nettype none

module trace_logger_chk #(
  parameter int AW = 4
) (
  input logic          clk,
  input logic          rst,
  input logic          wb_cyc,
  input logic          wb_stb,
  input logic          wb_ack,
  input logic          running,
  input logic          start,
  input logic          wr_en,
  input logic [AW-1:0] pc
);

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for more than one cycle");

  // Master drops the strobe right after seeing ack
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without an active bus cycle");

  // Capture only resumes through a start
  wr_while_running: assert property (@(posedge clk) disable iff (rst)
    !running && !start |=> !wr_en)
    else $error("memory write while capture is stopped");

  pc_stable: assert property (@(posedge clk) disable iff (rst)
    !(wr_en || start) |=> $stable(pc))
    else $error("write pointer moved without a write");

endmodule

bind trace_logger trace_logger_chk #(.AW(AW)) u_trace_logger_chk (
  .clk     (clk),
  .rst     (rst),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .running (running),
  .start   (start),
  .wr_en   (wr_en),
  .pc      (pc_mon)
);

`default_nettype wire

// ==== tests/trace_logger_tb.sv ====
/*
 * Trace logger testbench
 * Plays a table of probe values and hold lengths, then reads the trace
 * back over Wishbone and compares it with a model built from the samples
 */
`default_nettype none

module trace_logger_tb;

  import trace_pkg::*;

  localparam int AW = 4;
  localparam int DW = 40;
  localparam int TW = 8;
  localparam int N_ENT = 2**AW;
  localparam int N_ROWS = 24;
  localparam int HIST_LEN = 8192;
  localparam int TIMEOUT = 2000;

  logic             clk;
  logic             rst;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [3:0]       wb_sel;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;
  logic [DW-1:0]    probe;
  logic             running;
  logic [AW-1:0]    pc_mon;

  integer        seed;
  int            err_cnt = 0;
  int            chk_cnt = 0;
  int            edge_cnt = 0;
  logic [DW-1:0] hist [HIST_LEN];   // Probe as seen at each rising edge
  logic [DW-1:0] exp_data [N_ENT];
  logic [TW-1:0] exp_cnt [N_ENT];
  logic [DW-1:0] tab_val [N_ROWS];
  int            tab_hold [N_ROWS];

  trace_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  trace_logger #(
    .AW(AW),
    .DW(DW),
    .TW(TW)
  ) u_trace_logger (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .probe    (probe),
    .running  (running),
    .pc_mon   (pc_mon)
  );

  always @(posedge clk) begin
    if (edge_cnt < HIST_LEN) hist[edge_cnt] = probe;
    edge_cnt = edge_cnt + 1;
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("errors: %0d  checks: %0d", err_cnt + 1, chk_cnt);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic wait_ack();
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!wb_ack && t < TIMEOUT);
    if (!wb_ack) stop_on_timeout("wb_ack");
  endtask

  // Returns the edge count at which start takes effect
  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] dat,
                          output int eff_edge);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = dat;
    wait_ack();
    eff_edge = edge_cnt;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    wait_ack();
    dat = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic read_entry(input int idx, output logic [31:0] lo, output logic [31:0] hi);
    wb_read(WB_AW'((1 << MEM_BASE_BIT) | (idx << 1)), lo);
    wb_read(WB_AW'((1 << MEM_BASE_BIT) | (idx << 1) | 1), hi);
  endtask

  // A value that first shows at edge m is stored at edge m+2 together
  // with the cycles since the last write. 256 cycles without a write
  // force an entry with count 0.
  task automatic build_model(input int s, output int n_ent);
    int last_w;
    int n;
    last_w = s;
    n_ent = 0;
    for (n = s + 1; n < edge_cnt && n < HIST_LEN && n_ent < N_ENT; n++) begin
      if (hist[n-2] != hist[n-3] || n - last_w == 256) begin
        exp_data[n_ent] = hist[n-2];
        exp_cnt[n_ent] = TW'(n - last_w);
        n_ent++;
        last_w = n;
      end
    end
  endtask

  task automatic check_entries(input int first, input int last);
    logic [31:0] lo;
    logic [31:0] hi;
    for (int i = first; i <= last; i++) begin
      read_entry(i, lo, hi);
      check_word($sformatf("entry%0d_lo", i), lo, exp_data[i][31:0]);
      check_word($sformatf("entry%0d_hi", i), hi, {16'h0, exp_cnt[i], exp_data[i][39:32]});
    end
  endtask

  task automatic apply_rows(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(negedge clk);
      probe = tab_val[i];
      repeat (tab_hold[i] - 1) @(negedge clk);
    end
  endtask

  task automatic toggle_probe(input int times);
    repeat (times) begin
      @(negedge clk);
      probe = ~probe;
      @(negedge clk);
    end
  endtask

  task automatic wait_stopped();
    logic [31:0] st;
    int t;
    t = 0;
    do begin
      wb_read(WB_AW'(REG_STATUS), st);
      t++;
    end while (st[0] && t < TIMEOUT);
    if (st[0]) stop_on_timeout("capture to stop");
  endtask

  initial begin
    logic [31:0]   st;
    logic [31:0]   lo0;
    logic [31:0]   hi0;
    logic [31:0]   lo1;
    logic [31:0]   hi1;
    logic [DW-1:0] keep_data;
    logic [TW-1:0] keep_cnt;
    int            s;
    int            n_ent;
    int            t;

    seed = 32'h4625;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = 4'hf;
    probe = '0;

    tab_val[0] = 40'h12_3456_789a;
    tab_val[1] = 40'hff_0000_0001;
    tab_val[2] = 40'h00_dead_beef;  // Held past the counter range
    tab_val[3] = 40'h80_0000_0000;
    for (int i = 4; i < N_ROWS; i++) tab_val[i] = DW'({$random(seed), $random(seed)});
    for (int i = 0; i < N_ROWS; i++) tab_hold[i] = 1 + (i % 5);
    tab_hold[2] = 300;

    t = 0;
    while (rst && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (rst) stop_on_timeout("reset release");

    // Idle after reset
    wb_read(WB_AW'(REG_STATUS), st);
    check_word("status", st, 32'h0);
    read_entry(0, lo0, hi0);
    toggle_probe(8);
    read_entry(0, lo1, hi1);
    check_word("idle_entry0_lo", lo1, lo0);
    check_word("idle_entry0_hi", hi1, hi0);
    check_word("pc_mon", 32'(pc_mon), 32'h0);
    check_word("running", 32'(running), 32'h0);

    // Full capture run
    wb_write(WB_AW'(REG_CTRL), 32'h1, s);
    apply_rows(0, 19);
    wait_stopped();
    build_model(s, n_ent);
    check_word("entry_count", 32'(n_ent), 32'(N_ENT));
    check_entries(0, N_ENT - 1);

    // Stopped when full, later changes are not stored
    wb_read(WB_AW'(REG_STATUS), st);
    check_word("status", st, 32'h0);
    check_word("pc_mon", 32'(pc_mon), 32'h0);
    check_word("running", 32'(running), 32'h0);
    toggle_probe(6);
    check_entries(0, N_ENT - 1);
    keep_data = exp_data[N_ENT-1];
    keep_cnt = exp_cnt[N_ENT-1];

    // Rearm, new entries start at address 0
    wb_write(WB_AW'(REG_CTRL), 32'h1, s);
    apply_rows(20, 23);
    repeat (4) @(negedge clk);
    build_model(s, n_ent);
    check_word("pc_mon", 32'(pc_mon), 32'(n_ent));
    check_word("running", 32'(running), 32'h1);
    check_entries(0, n_ent - 1);
    exp_data[N_ENT-1] = keep_data;
    exp_cnt[N_ENT-1] = keep_cnt;
    check_entries(N_ENT - 1, N_ENT - 1);
    wb_read(WB_AW'(REG_STATUS), st);
    check_word("status", st, (32'(n_ent) << STATUS_PC_LSB) | 32'h1);

    $display("errors: %0d  checks: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== trace_logger.f ====
source/trace_pkg.sv
source/trace_ram.sv
source/trace_capture.sv
source/trace_readout.sv
source/trace_regs.sv
source/trace_logger.sv
tests/trace_clk_gen.sv
tests/trace_logger_chk.sv
tests/trace_logger_tb.sv
